//--- Bender.yml
package:
  name: main_board

sources:
  - hdl/main_pkg.sv
  - hdl/cpu_bus_if.sv
  - hdl/main_addr_dec.sv
  - hdl/input_sync.sv
  - hdl/player_port.sv
  - hdl/main_read_mux.sv
  - hdl/main_io_ctrl.sv
  - hdl/main_ram.sv
  - hdl/main_board.sv
  - target: simulation
    files:
      - dv/main_board_tb.sv

//--- dv/main_board_tb.sv
// main board testbench
// plays the external CPU on the bus ports, supplies ROM/video/object data
// from address patterns, models the map, cabinet formats and work RAM,
// and checks selects, read data, NVRAM loader, output latch and irq

`timescale 1ns/1ps
`default_nettype none

module main_board_tb;

    localparam int clk_period = 100;
    localparam int cen_clks   = 4;     // cpu_cen every fourth clk
    localparam int n_dec      = 200;
    localparam int n_ram      = 64;
    localparam int n_nv       = 16;
    localparam int n_cab      = 6;     // per layout
    localparam int n_lat      = 40;
    localparam int n_frame    = 8;
    // clocks per test section, summed, then doubled for margin
    localparam int run_clks = 8 + n_dec + 2 * n_ram * cen_clks
                              + n_nv * (3 + 2 * cen_clks)
                              + 2 * n_cab * (4 + 5 * cen_clks)
                              + (n_lat + 3 * n_frame) * cen_clks + 200;
    localparam int wd_ns = 2 * run_clks * clk_period;

    logic        clk, rst;
    logic        cpu_cen, rnw, vma;
    logic [15:0] addr;
    logic [7:0]  cpu_dout, cpu_din;
    logic        rom_cs, vram_cs, objram_cs, snd_data_cs;
    logic [7:0]  rom_data, vram_dout, obj_dout;
    logic        snd_irq, flip, obj_frame, irq_n, lvbl, dip_pause;
    logic [3:0]  start_button;
    logic [1:0]  coin_input;
    logic [6:0]  joystick1, joystick2, joystick3, joystick4;
    logic        service, is_hyper;
    logic [7:0]  dipsw_a, dipsw_b;
    logic [2:0]  dipsw_c;
    logic [15:0] ioctl_addr;
    logic        ioctl_ram, ioctl_wr;
    logic [7:0]  ioctl_dout, ioctl_din;

    logic [7:0]  shadow [0:4095];   // work RAM model
    logic [7:0]  exp_din, got_din;
    int          err_cnt = 0;
    event        rd_done;

    main_board u_dut (
        .clk(clk), .rst(rst), .cpu_cen(cpu_cen), .addr(addr), .rnw(rnw), .vma(vma),
        .cpu_dout(cpu_dout), .cpu_din(cpu_din), .rom_cs(rom_cs), .rom_data(rom_data),
        .vram_cs(vram_cs), .vram_dout(vram_dout), .objram_cs(objram_cs),
        .obj_dout(obj_dout), .snd_data_cs(snd_data_cs), .snd_irq(snd_irq),
        .flip(flip), .obj_frame(obj_frame), .irq_n(irq_n), .lvbl(lvbl),
        .dip_pause(dip_pause), .start_button(start_button), .coin_input(coin_input),
        .joystick1(joystick1), .joystick2(joystick2), .joystick3(joystick3),
        .joystick4(joystick4), .service(service), .is_hyper(is_hyper),
        .dipsw_a(dipsw_a), .dipsw_b(dipsw_b), .dipsw_c(dipsw_c),
        .ioctl_addr(ioctl_addr), .ioctl_ram(ioctl_ram), .ioctl_wr(ioctl_wr),
        .ioctl_dout(ioctl_dout), .ioctl_din(ioctl_din)
    );

    // device data, each byte a function of the full address
    function automatic logic [7:0] rom_pat(input logic [15:0] a);
        return a[15:8] ^ {a[6:0], a[7]};
    endfunction

    function automatic logic [7:0] vram_pat(input logic [15:0] a);
        return a[7:0] ^ a[15:8] ^ 8'ha5;
    endfunction

    function automatic logic [7:0] obj_pat(input logic [15:0] a);
        return ~(a[7:0] + a[15:8]);
    endfunction

    assign rom_data  = rom_pat(addr);     // no wait states
    assign vram_dout = vram_pat(addr);
    assign obj_dout  = obj_pat(addr);

    // player byte, joystick bits: 0 right 1 left 2 down 3 up 4..6 buttons
    function automatic logic [7:0] port_fmt(input logic [6:0] ja, input logic [6:0] jb,
                                            input logic st, input logic hy);
        if (hy)
            return {1'b1, jb[4], jb[5], jb[6], st, ja[4], ja[5], ja[6]};
        return {2'b10, ja[5], ja[4], ja[2], ja[3], ja[0], ja[1]};
    endfunction

    function automatic logic [7:0] cab_byte(input logic [1:0] off);
        case (off)
            2'd0: return {dipsw_c, start_button[1:0], service, coin_input};
            2'd1: return port_fmt(joystick1, joystick2, start_button[2], is_hyper);
            2'd2: return is_hyper ? port_fmt(joystick3, joystick4, start_button[3], 1'b1)
                                  : port_fmt(joystick2, joystick4, start_button[3], 1'b0);
            default: return dipsw_a;
        endcase
    endfunction

    // {rom, vram, ram, obj, intst, iow, snd, in5, ior}
    function automatic logic [8:0] exp_sel(input logic [15:0] a, input logic r,
                                           input logic v);
        logic [8:0] s;
        s = '0;
        if (v && a[15:13] >= 3'd2 && r)
            s[8] = 1'b1;
        if (v && a[15:13] == 3'd1)
            s[a[12] ? 6 : 7] = 1'b1;        // upper 4 KB of page 1 is work RAM
        if (v && a[15:13] == 3'd0 && a[12:10] == 3'd4)
            s[5] = 1'b1;
        if (v && a[15:13] == 3'd0 && a[12:10] == 3'd5) begin
            case (a[9:7])
                3'd0: s[4] = 1'b1;
                3'd1: s[3] = 1'b1;
                3'd2: s[2] = 1'b1;
                3'd4: s[1] = 1'b1;
                3'd5: s[0] = 1'b1;
                default: ;
            endcase
        end
        return s;
    endfunction

    // expected cpu_din for a stable address
    function automatic logic [7:0] ref_din(input logic [15:0] a, input logic r,
                                           input logic v);
        logic [7:0] q;
        q = 8'hff;                           // open bus
        if (!v)
            q = 8'hff;
        else if (a[15:13] >= 3'd2)
            q = r ? rom_pat(a) : 8'hff;
        else if (a[15:13] == 3'd1)
            q = a[12] ? shadow[a[11:0]] : vram_pat(a);
        else if (a[12:10] == 3'd4)
            q = obj_pat(a);
        else if (a[12:10] == 3'd5 && a[9:7] == 3'd5)
            q = cab_byte(a[1:0]);
        else if (a[12:10] == 3'd5 && a[9:7] == 3'd4)
            q = dipsw_b;
        return q;
    endfunction

    task automatic check_val(input string name, input logic [15:0] got,
                             input logic [15:0] exp);
        if (got !== exp) begin
            err_cnt++;
            $display("MISMATCH time=%0t %s got=%h expected=%h", $time, name, got, exp);
            $display("TB FAILED");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    // called at a falling edge, cen on the last clk, returns at a falling edge
    task automatic bus_op(input logic [15:0] a, input logic r, input logic [7:0] d,
                          output logic [7:0] q);
        addr     = a;
        rnw      = r;
        vma      = 1'b1;
        cpu_dout = d;
        repeat (cen_clks - 1) @(negedge clk);
        cpu_cen = 1'b1;
        @(negedge clk);
        cpu_cen = 1'b0;
        q = cpu_din;
    endtask

    task automatic bus_read(input logic [15:0] a);
        logic [7:0] q;
        bus_op(a, 1'b1, 8'h00, q);
        exp_din = ref_din(a, 1'b1, 1'b1);
        got_din = q;
        -> rd_done;
    endtask

    task automatic bus_write(input logic [15:0] a, input logic [7:0] d);
        logic [7:0] q;
        bus_op(a, 1'b0, d, q);
        if (exp_sel(a, 1'b0, 1'b1) == 9'b001_000_000)
            shadow[a[11:0]] = d;
    endtask

    // loader write, one clk
    task automatic nv_load(input logic [10:0] ia, input logic [7:0] d);
        ioctl_addr = {5'b0, ia};
        ioctl_dout = d;
        ioctl_ram  = 1'b1;
        ioctl_wr   = 1'b1;
        @(negedge clk);
        ioctl_wr   = 1'b0;
        shadow[{1'b1, ia}] = d;
    endtask

    task automatic nv_peek(input logic [10:0] ia);
        ioctl_addr = {5'b0, ia};
        @(negedge clk);                      // ioctl_din registered
        check_val("ioctl_din", ioctl_din, shadow[{1'b1, ia}]);
    endtask

    task automatic wait_irq(input logic level, input int max_clks);
        int n;
        n = 0;
        while (irq_n !== level && n < max_clks) begin
            @(negedge clk);
            n++;
        end
        if (irq_n !== level) begin
            err_cnt++;
            $display("irq_n did not go to %b within %0d clocks", level, max_clks);
            $display("TB FAILED");
            $fatal(1, "irq_n timeout");
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // read data comparison
    always @(rd_done) check_val("cpu_din", got_din, exp_din);

    initial begin
        #(wd_ns);
        $display("watchdog expired after %0d ns, test did not finish", wd_ns);
        $display("TB FAILED");
        $fatal(1, "watchdog");
    end

    initial begin
        logic [31:0] r, r2;
        logic [15:0] a;
        logic [8:0]  sel_e;
        logic [11:0] ram_q[$];
        logic        exp_flip, exp_snd, exp_frame;
        r = $urandom(32'h82b8_478f);         // seed once
        {rst, cpu_cen, rnw, vma, addr, cpu_dout} = {1'b1, 1'b0, 1'b1, 1'b0, 16'h0, 8'h0};
        {lvbl, dip_pause, start_button, coin_input, service, is_hyper} = 10'b11_0000_00_0_0;
        {joystick1, joystick2, joystick3, joystick4} = '0;
        {dipsw_a, dipsw_b, dipsw_c} = '0;
        {ioctl_addr, ioctl_ram, ioctl_wr, ioctl_dout} = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        check_val("flip", flip, 1'b0);
        check_val("snd_irq", snd_irq, 1'b0);
        check_val("obj_frame", obj_frame, 1'b0);
        check_val("irq_n", irq_n, 1'b1);

        // decoding, no cen so nothing is written
        for (int i = 0; i < n_dec; i++) begin
            r    = $urandom;
            a    = r[15:0];
            if (r[16])
                a[15:10] = 6'b000101;       // bias towards the I/O block
            addr = a;
            rnw  = r[17];
            vma  = (r[20:18] != 3'd0);
            @(negedge clk);
            sel_e = exp_sel(a, rnw, vma);
            check_val("chip selects", {u_dut.rom_cs, u_dut.vram_cs, u_dut.ram_cs,
                      u_dut.objram_cs, u_dut.intst_cs, u_dut.iow_cs, u_dut.snd_data_cs,
                      u_dut.in5_cs, u_dut.ior_cs}, sel_e);
            check_val("top selects", {rom_cs, vram_cs, objram_cs, snd_data_cs},
                      {sel_e[8:7], sel_e[5], sel_e[2]});
            if (!sel_e[6])    // RAM data lags a clk, checked below
                check_val("cpu_din", cpu_din, ref_din(a, rnw, vma));
        end

        // work RAM over 4 KB
        for (int i = 0; i < n_ram; i++) begin
            r = $urandom;
            bus_write({4'h3, r[11:0]}, r[19:12]);
            ram_q.push_back(r[11:0]);
        end
        foreach (ram_q[i])
            bus_read({4'h3, ram_q[i]});

        // NVRAM, loader then CPU side
        for (int i = 0; i < n_nv; i++) begin
            r = $urandom;
            nv_load(r[10:0], r[18:11]);
            bus_read({5'b00111, r[10:0]});
            nv_peek(r[10:0]);
            bus_write({5'b00111, r[21:11]}, r[29:22]);
            nv_peek(r[21:11]);
        end
        ioctl_ram = 1'b0;

        // cabinet inputs, both layouts
        for (int hy = 0; hy < 2; hy++) begin
            for (int k = 0; k < n_cab; k++) begin
                r  = $urandom;
                r2 = $urandom;
                is_hyper = hy[0];
                {joystick4, joystick3, joystick2, joystick1} = r[27:0];
                {start_button, coin_input, service} = {r2[3:0], r2[5:4], r2[6]};
                {dipsw_c, dipsw_b, dipsw_a} = r2[26:8];
                a    = {9'b0001_0110_1, r[31:28], r2[29:27]};
                addr = a;
                rnw  = 1'b1;
                vma  = 1'b1;
                repeat (3) @(posedge clk);   // two sync stages, then cpu_din
                @(negedge clk);
                check_val("cpu_din", cpu_din, ref_din(a, 1'b1, 1'b1));
                for (int off = 0; off < 4; off++) begin
                    a      = 16'h1680;
                    a[1:0] = off[1:0];
                    bus_read(a);
                end
                bus_read({9'b0001_0110_0, r2[31:25]});   // switch bank B
            end
        end

        // output latch, any offset bits above the index
        exp_flip = 1'b0;
        exp_snd  = 1'b0;
        for (int i = 0; i < n_lat; i++) begin
            r = $urandom;
            bus_write({9'b0001_0100_1, r[6:0]}, r[15:8]);
            if (r[2:0] == 3'd0)
                exp_flip = r[8];
            if (r[2:0] == 3'd1)
                exp_snd = r[8];
            check_val("flip", flip, exp_flip);
            check_val("snd_irq", snd_irq, exp_snd);
        end

        // frame toggle once per new intst access
        exp_frame = 1'b0;                    // no intst access with cen so far
        bus_read(16'h0000);
        for (int i = 0; i < n_frame; i++) begin
            r = $urandom;
            bus_read({9'b0001_0100_0, r[6:0]});
            exp_frame = ~exp_frame;
            check_val("obj_frame", obj_frame, exp_frame);
            bus_read({9'b0001_0100_0, r[13:7]});   // back to back, no toggle
            check_val("obj_frame", obj_frame, exp_frame);
            bus_read(16'h0000);
        end

        // vblank irq
        bus_write(16'h1487, 8'h01);         // irq_clrn high
        dip_pause = 1'b1;
        lvbl      = 1'b0;
        wait_irq(1'b0, 4);
        lvbl = 1'b1;
        @(negedge clk);
        check_val("irq_n", irq_n, 1'b0);    // held until cleared
        bus_write(16'h1487, 8'h00);
        wait_irq(1'b1, 4);
        lvbl = 1'b0;                        // fall while cleared
        repeat (3) @(negedge clk);
        check_val("irq_n", irq_n, 1'b1);
        lvbl = 1'b1;
        bus_write(16'h1487, 8'h01);
        dip_pause = 1'b0;
        lvbl      = 1'b0;                   // paused, no irq
        repeat (3) @(negedge clk);
        check_val("irq_n", irq_n, 1'b1);
        lvbl = 1'b1;
        @(negedge clk);

        if (err_cnt == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- hdl/cpu_bus_if.sv
// main CPU bus
// clock enable, address, direction, valid access and write data
// as seen by the address decoder, read mux, latch and RAM

`timescale 1ns/1ps
`default_nettype none

interface cpu_bus_if;
    logic        cen;    // one clk wide, once per CPU cycle
    logic [15:0] addr;
    logic        rnw;    // high on reads
    logic        vma;    // valid memory access
    logic [7:0]  dout;   // CPU write data

    // driven from the top level ports
    modport src  (output cen, addr, rnw, vma, dout);

    // everything on the board only listens
    modport user (input  cen, addr, rnw, vma, dout);
endinterface

`default_nettype wire

//--- hdl/input_sync.sv
// cabinet input synchronizer
// brings coins, start buttons, service, the hyper mode level, joysticks
// and board jumpers into clk through two flops, then splits them
// into the groups used by the player ports and the system byte

`timescale 1ns/1ps
`default_nettype none

module input_sync (
    input  logic            clk,
    input  logic            rst,
    input  logic [3:0]      start_button,
    input  logic [1:0]      coin_input,
    input  logic            service,
    input  logic            is_hyper,
    input  logic [6:0]      joystick1,
    input  logic [6:0]      joystick2,
    input  logic [6:0]      joystick3,
    input  logic [6:0]      joystick4,
    input  logic [2:0]      dipsw_c,
    output logic [3:0][6:0] joy_s,     // joy_s[0] is joystick1
    output logic [3:0]      start_s,
    output logic            hyper_s,
    output logic [7:0]      sys_byte
);
    // 3 jumpers, 4x7 joystick, 4 start, hyper, service, 2 coins
    logic [38:0] raw, meta, sync;
    logic [2:0]  dip_s;
    logic        service_s;
    logic [1:0]  coin_s;

    assign raw = {dipsw_c, joystick4, joystick3, joystick2, joystick1,
                  start_button, is_hyper, service, coin_input};

    always_ff @(posedge clk) begin
        if (rst) begin
            meta <= '0;
            sync <= '0;
        end else begin
            meta <= raw;    // first stage, may go metastable
            sync <= meta;
        end
    end

    assign {dip_s, joy_s, start_s, hyper_s, service_s, coin_s} = sync;

    // port 0 of the input block
    assign sys_byte = {dip_s, start_s[1:0], service_s, coin_s};

endmodule

`default_nettype wire

//--- hdl/main_addr_dec.sv
// main CPU address decoder
// turns the bus address into chip select levels for ROM, video RAM,
// work RAM, object RAM and the I/O block registers
// all selects are combinational and qualified by vma

`timescale 1ns/1ps
`default_nettype none

module main_addr_dec (
    cpu_bus_if.user bus,
    output logic    rom_cs,
    output logic    vram_cs,
    output logic    ram_cs,
    output logic    objram_cs,
    output logic    intst_cs,
    output logic    iow_cs,
    output logic    snd_data_cs,
    output logic    in5_cs,
    output logic    ior_cs
);
    import main_pkg::*;

    cpu_addr_u a;

    assign a = bus.addr;

    always_comb begin
        // ROM only answers reads, 4000-FFFF
        rom_cs      = bus.vma && bus.rnw && (a.mem_view.page >= rom_page_min);
        vram_cs     = 1'b0;
        ram_cs      = 1'b0;
        objram_cs   = 1'b0;
        intst_cs    = 1'b0;
        iow_cs      = 1'b0;
        snd_data_cs = 1'b0;
        in5_cs      = 1'b0;
        ior_cs      = 1'b0;

        if (bus.vma) begin
            if (a.mem_view.page == page_vid) begin
                case (a.mem_view.window)
                    2'd0, 2'd1: vram_cs = 1'b1;   // two 2 KB video banks
                    2'd2, 2'd3: ram_cs  = 1'b1;   // window 3 is the NVRAM half
                    default: ;
                endcase
            end
            if (a.mem_view.page == page_io) begin
                if (a.io_view.block == blk_obj)
                    objram_cs = 1'b1;
                else if (a.io_view.block == blk_io) begin
                    case (a.io_view.sub)
                        sub_intst: intst_cs    = 1'b1;
                        sub_iow:   iow_cs      = 1'b1;
                        sub_snd:   snd_data_cs = 1'b1;
                        sub_in5:   in5_cs      = 1'b1;
                        sub_ior:   ior_cs      = 1'b1;
                        default: ;                     // 3, 6, 7 unused
                    endcase
                end
            end
        end
    end

    // no two devices may ever drive the read bus together
    a_sel_onehot: assert final ($onehot0({rom_cs, vram_cs, ram_cs, objram_cs,
                                          intst_cs, iow_cs, snd_data_cs,
                                          in5_cs, ior_cs}))
        else $error("address decoder raised more than one select for %h", bus.addr);

endmodule

`default_nettype wire

//--- hdl/main_board.sv
// main CPU board bus logic, CPU kept outside
// address decoding, work RAM / NVRAM, cabinet input formatting,
// CPU read data register, output latch and vblank interrupt

`timescale 1ns/1ps
`default_nettype none

module main_board (
    input  logic        clk,
    input  logic        rst,
    // CPU bus
    input  logic        cpu_cen,
    input  logic [15:0] addr,
    input  logic        rnw,
    input  logic        vma,
    input  logic [7:0]  cpu_dout,
    output logic [7:0]  cpu_din,
    // memories
    output logic        rom_cs,
    input  logic [7:0]  rom_data,
    output logic        vram_cs,
    input  logic [7:0]  vram_dout,
    output logic        objram_cs,
    input  logic [7:0]  obj_dout,
    output logic        snd_data_cs,
    // control
    output logic        snd_irq,
    output logic        flip,
    output logic        obj_frame,
    output logic        irq_n,
    input  logic        lvbl,
    input  logic        dip_pause,
    // cabinet
    input  logic [3:0]  start_button,
    input  logic [1:0]  coin_input,
    input  logic [6:0]  joystick1,
    input  logic [6:0]  joystick2,
    input  logic [6:0]  joystick3,
    input  logic [6:0]  joystick4,
    input  logic        service,
    input  logic        is_hyper,
    input  logic [7:0]  dipsw_a,
    input  logic [7:0]  dipsw_b,
    input  logic [2:0]  dipsw_c,     // board jumpers
    // NVRAM loader
    input  logic [15:0] ioctl_addr,
    input  logic        ioctl_ram,
    input  logic        ioctl_wr,
    input  logic [7:0]  ioctl_dout,
    output logic [7:0]  ioctl_din
);

    cpu_bus_if bus();

    logic            ram_cs, intst_cs, iow_cs, in5_cs, ior_cs;
    logic [7:0]      ram_dout, sys_byte;
    logic [3:0][6:0] joy_s;
    logic [3:0]      start_s;
    logic            hyper_s;
    logic [1:0][7:0] port_bytes;

    // external CPU drives the board bus
    assign bus.cen  = cpu_cen;
    assign bus.addr = addr;
    assign bus.rnw  = rnw;
    assign bus.vma  = vma;
    assign bus.dout = cpu_dout;

    main_addr_dec u_dec (
        .bus(bus), .rom_cs(rom_cs), .vram_cs(vram_cs), .ram_cs(ram_cs),
        .objram_cs(objram_cs), .intst_cs(intst_cs), .iow_cs(iow_cs),
        .snd_data_cs(snd_data_cs), .in5_cs(in5_cs), .ior_cs(ior_cs)
    );

    input_sync u_sync (
        .clk(clk), .rst(rst), .start_button(start_button), .coin_input(coin_input),
        .service(service), .is_hyper(is_hyper), .joystick1(joystick1),
        .joystick2(joystick2), .joystick3(joystick3), .joystick4(joystick4),
        .dipsw_c(dipsw_c), .joy_s(joy_s), .start_s(start_s), .hyper_s(hyper_s),
        .sys_byte(sys_byte)
    );

    // port g takes sticks 2g/2g+1 in hyper mode, stick g otherwise
    for (genvar g = 0; g < 2; g++) begin : g_player
        logic [6:0] joy_a;
        assign joy_a = hyper_s ? joy_s[2*g] : joy_s[g];
        player_port u_port (
            .joy_a(joy_a), .joy_b(joy_s[2*g+1]), .start(start_s[2+g]),
            .hyper(hyper_s), .port_byte(port_bytes[g])
        );
    end

    main_read_mux u_mux (
        .clk(clk), .bus(bus), .rom_cs(rom_cs), .vram_cs(vram_cs), .ram_cs(ram_cs),
        .objram_cs(objram_cs), .ior_cs(ior_cs), .in5_cs(in5_cs), .rom_data(rom_data),
        .vram_dout(vram_dout), .obj_dout(obj_dout), .ram_dout(ram_dout),
        .sys_byte(sys_byte), .dipsw_a(dipsw_a), .dipsw_b(dipsw_b),
        .port_bytes(port_bytes), .cpu_din(cpu_din)
    );

    main_io_ctrl u_io (
        .clk(clk), .rst(rst), .bus(bus), .iow_cs(iow_cs), .intst_cs(intst_cs),
        .lvbl(lvbl), .dip_pause(dip_pause), .flip(flip), .snd_irq(snd_irq),
        .obj_frame(obj_frame), .irq_n(irq_n)
    );

    main_ram u_ram (
        .clk(clk), .bus(bus), .ram_cs(ram_cs), .ram_dout(ram_dout),
        .ioctl_addr(ioctl_addr), .ioctl_ram(ioctl_ram), .ioctl_wr(ioctl_wr),
        .ioctl_dout(ioctl_dout), .ioctl_din(ioctl_din)
    );

endmodule

`default_nettype wire

//--- hdl/main_io_ctrl.sv
// main board control outputs
// 74LS259 style addressable latch for flip, sound irq and irq clear,
// object frame toggle on interrupt status accesses and the
// vblank interrupt flip-flop

`timescale 1ns/1ps
`default_nettype none

module main_io_ctrl (
    input  logic    clk,
    input  logic    rst,
    cpu_bus_if.user bus,
    input  logic    iow_cs,
    input  logic    intst_cs,
    input  logic    lvbl,        // low during vertical blank
    input  logic    dip_pause,   // low freezes the game
    output logic    flip,
    output logic    snd_irq,
    output logic    obj_frame,
    output logic    irq_n
);
    import main_pkg::*;

    logic irq_clrn;
    logic intst_l;     // intst_cs seen at the previous cen
    logic lvbl_l;
    logic vb_fall;

    // latch and frame toggle, all on the CPU cen
    always_ff @(posedge clk) begin
        if (rst) begin
            flip      <= 1'b0;
            snd_irq   <= 1'b0;
            irq_clrn  <= 1'b0;
            obj_frame <= 1'b0;
            intst_l   <= 1'b0;
        end else if (bus.cen) begin
            intst_l <= intst_cs;
            if (intst_cs && !intst_l)
                obj_frame <= ~obj_frame;   // one toggle per access, not per cycle
            if (iow_cs && !bus.rnw) begin
                case (bus.addr[2:0])
                    lat_flip:     flip     <= bus.dout[0];
                    lat_snd_irq:  snd_irq  <= bus.dout[0];
                    lat_irq_clrn: irq_clrn <= bus.dout[0];
                    default: ;     // counters and test bits dropped
                endcase
            end
        end
    end

    assign vb_fall = lvbl_l && !lvbl;

    // irq flip-flop, clear wins over set
    always_ff @(posedge clk) begin
        if (rst) begin
            lvbl_l <= 1'b0;    // no fake edge right after reset
            irq_n  <= 1'b1;
        end else begin
            lvbl_l <= lvbl;
            if (!irq_clrn)
                irq_n <= 1'b1;
            else if (vb_fall && dip_pause)
                irq_n <= 1'b0;
        end
    end

    // latched clear bit must keep the CPU irq line released
    a_irq_held_off: assert property (@(posedge clk) disable iff (rst)
        !irq_clrn |=> irq_n)
        else $error("irq_n asserted while irq_clrn is low");

endmodule

`default_nettype wire

//--- hdl/main_pkg.sv
// main board definitions
// address map pages, blocks and sub-selects of the main CPU bus,
// output latch bit indices, RAM widths and the decoded address word

`default_nettype none

package main_pkg;

    // 8 KB pages, addr[15:13]
    localparam logic [2:0] rom_page_min = 3'd2;   // pages 2..7 are program ROM
    localparam logic [2:0] page_vid     = 3'd1;   // video RAM + work RAM window
    localparam logic [2:0] page_io      = 3'd0;   // object RAM + I/O window

    // 1 KB blocks inside the I/O page, addr[12:10]
    localparam logic [2:0] blk_obj = 3'd4;
    localparam logic [2:0] blk_io  = 3'd5;

    // I/O sub-selects inside blk_io, addr[9:7]
    localparam logic [2:0] sub_intst = 3'd0;  // interrupt status, toggles obj frame
    localparam logic [2:0] sub_iow   = 3'd1;  // addressable output latch
    localparam logic [2:0] sub_snd   = 3'd2;  // sound latch
    localparam logic [2:0] sub_in5   = 3'd4;  // switch bank B
    localparam logic [2:0] sub_ior   = 3'd5;  // cabinet inputs

    // output latch bits, addr[2:0] on a write to sub_iow
    localparam logic [2:0] lat_flip     = 3'd0;
    localparam logic [2:0] lat_snd_irq  = 3'd1;
    localparam logic [2:0] lat_irq_clrn = 3'd7;  // low holds the vblank irq off
    // bits 2..6 are coin counters and test outputs, not kept here

    // work RAM is 4 KB, top half battery backed
    localparam int ram_aw = 12;
    localparam int nv_aw  = 11;

    // memory side view of a CPU address
    typedef struct packed {
        logic [2:0]  page;
        logic [1:0]  window;   // 2 KB windows in the video page
        logic [10:0] offset;
    } mem_view_t;

    // I/O side view of the same word
    typedef struct packed {
        logic [2:0] page;
        logic [2:0] block;
        logic [2:0] sub;
        logic [6:0] reg_off;   // register offset, low bits pick latch bit / input port
    } io_view_t;

    // one 16-bit word, decoded both ways
    typedef union packed {
        mem_view_t mem_view;
        io_view_t  io_view;
    } cpu_addr_u;

endpackage

`default_nettype wire

//--- hdl/main_ram.sv
// main work RAM
// 4 KB of CPU RAM, the upper 2 KB battery backed
// second port lets the loader read and write the NVRAM half

`timescale 1ns/1ps
`default_nettype none

module main_ram (
    input  logic        clk,
    cpu_bus_if.user     bus,
    input  logic        ram_cs,
    output logic [7:0]  ram_dout,
    input  logic [15:0] ioctl_addr,
    input  logic        ioctl_ram,
    input  logic        ioctl_wr,
    input  logic [7:0]  ioctl_dout,
    output logic [7:0]  ioctl_din
);
    import main_pkg::*;

    logic [7:0]        mem [0:2**ram_aw-1];
    logic [ram_aw-1:0] cpu_a, nv_a;
    logic              cpu_we, nv_we;

    assign cpu_a  = bus.addr[ram_aw-1:0];
    assign cpu_we = bus.cen && ram_cs && !bus.rnw;

    // loader only sees 0000-07FF, mapped on top of the work RAM
    assign nv_a  = {{(ram_aw-nv_aw){1'b1}}, ioctl_addr[nv_aw-1:0]};
    assign nv_we = ioctl_ram && ioctl_wr && (ioctl_addr[15:nv_aw] == '0);

    always_ff @(posedge clk) begin
        if (cpu_we)
            mem[cpu_a] <= bus.dout;
        if (nv_we)
            mem[nv_a] <= ioctl_dout;
        ram_dout  <= mem[cpu_a];   // one clk read latency
        ioctl_din <= mem[nv_a];
    end

    // both ports writing one cell gives an undefined result
    a_no_wr_clash: assert property (@(posedge clk)
        !(cpu_we && nv_we && (cpu_a == nv_a)))
        else $error("CPU and loader write NVRAM address %h together", cpu_a);

endmodule

`default_nettype wire

//--- hdl/main_read_mux.sv
// main CPU read data mux
// picks the cabinet byte by the low address bits and registers
// the CPU read data from the selected device on every clk

`timescale 1ns/1ps
`default_nettype none

module main_read_mux (
    input  logic            clk,
    cpu_bus_if.user         bus,
    input  logic            rom_cs,
    input  logic            vram_cs,
    input  logic            ram_cs,
    input  logic            objram_cs,
    input  logic            ior_cs,
    input  logic            in5_cs,
    input  logic [7:0]      rom_data,
    input  logic [7:0]      vram_dout,
    input  logic [7:0]      obj_dout,
    input  logic [7:0]      ram_dout,
    input  logic [7:0]      sys_byte,
    input  logic [7:0]      dipsw_a,
    input  logic [7:0]      dipsw_b,
    input  logic [1:0][7:0] port_bytes,
    output logic [7:0]      cpu_din
);
    import main_pkg::*;

    cpu_addr_u  a;
    logic [7:0] cabinet;

    assign a = bus.addr;

    // combinational so an input change lands in cpu_din on the next edge
    always_comb begin
        case (a.io_view.reg_off[1:0])
            2'd0:    cabinet = sys_byte;
            2'd1:    cabinet = port_bytes[0];   // players 1/2
            2'd2:    cabinet = port_bytes[1];   // players 3/4 or P2
            default: cabinet = dipsw_a;
        endcase
    end

    // registered on every clk, cen does not matter here
    always_ff @(posedge clk) begin
        if (rom_cs)
            cpu_din <= rom_data;
        else if (vram_cs)
            cpu_din <= vram_dout;
        else if (ram_cs)
            cpu_din <= ram_dout;
        else if (objram_cs)
            cpu_din <= obj_dout;
        else if (ior_cs)
            cpu_din <= cabinet;
        else if (in5_cs)
            cpu_din <= dipsw_b;
        else
            cpu_din <= 8'hff;   // open bus pulls high
    end

endmodule

`default_nettype wire

//--- hdl/player_port.sv
// player input port formatter
// packs two joysticks and one start button into a cabinet byte
// hyper (four player) layout keeps three buttons of each stick,
// normal layout keeps two buttons and the directions of joy_a
// joystick bits: 0 right, 1 left, 2 down, 3 up, 4..6 buttons

`timescale 1ns/1ps
`default_nettype none

module player_port (
    input  logic [6:0] joy_a,
    input  logic [6:0] joy_b,
    input  logic       start,
    input  logic       hyper,
    output logic [7:0] port_byte
);

    // button order is mirrored on the hyper harness
    function automatic logic [2:0] rev3(input logic [2:0] x);
        return {x[0], x[1], x[2]};
    endfunction

    always_comb begin
        if (hyper)
            port_byte = {1'b1, rev3(joy_b[6:4]), start, rev3(joy_a[6:4])};
        else
            port_byte = {2'b10,              // fixed marker, bit 6 high blocks boot
                         joy_a[5:4],         // two buttons
                         joy_a[2],           // down
                         joy_a[3],           // up
                         joy_a[0],           // right
                         joy_a[1]};          // left
    end

endmodule

`default_nettype wire

//--- sim.f
hdl/main_pkg.sv
hdl/cpu_bus_if.sv
hdl/main_addr_dec.sv
hdl/input_sync.sv
hdl/player_port.sv
hdl/main_read_mux.sv
hdl/main_io_ctrl.sv
hdl/main_ram.sv
hdl/main_board.sv
dv/main_board_tb.sv
